//--- verilog/ossc_pkg.sv
`default_nettype none
/* Shared widths, sys_ctrl bit positions, OSD colours and timing constants
   of the video top level. Every module refers to them by scoped name. */
package ossc_pkg;

    localparam int PIX_W = 8;
    localparam int RGB_W = 3 * PIX_W;
    localparam int BTN_W = 6;

    // PWM duty fields and the shared counter of period 1024
    localparam int DUTY_W    = 4;
    localparam int PWM_CNT_W = 10;

    localparam int REFRESH_CNT_W = 10;
    localparam logic [REFRESH_CNT_W-1:0] REFRESH_INTERVAL = 10'd842;

    localparam int RESYNC_LED_BITS = 24;

    // sys_ctrl word from the CPU
    localparam int SYS_POWERON_BIT  = 0;
    localparam int CAPTURE_SEL_BIT  = 7;
    localparam int AUDMUX_SEL_BIT   = 11;
    localparam int FRAMELOCK_BIT    = 14;
    localparam int HDMIRX_SPDIF_BIT = 15;
    localparam int FAN_DUTY_LSB     = 16;
    localparam int LED_DUTY_LSB     = 20;
    localparam int REFRESH_EN_BIT   = 24;

    // OSD palette, indexed by osd_color
    localparam logic [RGB_W-1:0] OSD_BLACK  = 24'h000000;
    localparam logic [RGB_W-1:0] OSD_BLUE   = 24'h0000ff;
    localparam logic [RGB_W-1:0] OSD_YELLOW = 24'hffff00;
    localparam logic [RGB_W-1:0] OSD_WHITE  = 24'hffffff;

endpackage
`default_nettype wire

//--- verilog/capture_mux.sv
`timescale 1ns/1ps
`default_nettype none
/* Input registers of the RGB digitizer and HDMI receiver buses and the
   registered source select. Digitizer path is 2 cycles, receiver path 3. */
module capture_mux (
    input  wire                        pclk_out,
    input  wire                        po_reset_n,
    input  wire                        capture_sel_i,
    input  wire [ossc_pkg::PIX_W-1:0]  isl_r_i,
    input  wire [ossc_pkg::PIX_W-1:0]  isl_g_i,
    input  wire [ossc_pkg::PIX_W-1:0]  isl_b_i,
    input  wire                        isl_hsync_i,
    input  wire                        isl_vsync_i,
    input  wire                        isl_de_i,
    input  wire [ossc_pkg::PIX_W-1:0]  hdmirx_r_i,
    input  wire [ossc_pkg::PIX_W-1:0]  hdmirx_g_i,
    input  wire [ossc_pkg::PIX_W-1:0]  hdmirx_b_i,
    input  wire                        hdmirx_hsync_i,
    input  wire                        hdmirx_vsync_i,
    input  wire                        hdmirx_de_i,
    output logic [ossc_pkg::RGB_W-1:0] capt_rgb_o,
    output logic                       capt_hsync_o,
    output logic                       capt_vsync_o,
    output logic                       capt_de_o
);

    logic [ossc_pkg::RGB_W-1:0] isl_rgb_q;
    logic [ossc_pkg::RGB_W-1:0] rx_rgb_iq;
    logic [ossc_pkg::RGB_W-1:0] rx_rgb_q;
    // Sync fields kept as {hsync, vsync, de}
    logic [2:0] isl_sync_q;
    logic [2:0] rx_sync_iq;
    logic [2:0] rx_sync_q;

    always_ff @(posedge pclk_out) begin
        isl_rgb_q <= {isl_r_i, isl_g_i, isl_b_i};
        // Receiver pads get an extra stage
        rx_rgb_iq <= {hdmirx_r_i, hdmirx_g_i, hdmirx_b_i};
        rx_rgb_q  <= rx_rgb_iq;
        capt_rgb_o <= capture_sel_i ? rx_rgb_q : isl_rgb_q;
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            isl_sync_q <= '0;
            rx_sync_iq <= '0;
            rx_sync_q  <= '0;
            {capt_hsync_o, capt_vsync_o, capt_de_o} <= '0;
        end else begin
            isl_sync_q <= {isl_hsync_i, isl_vsync_i, isl_de_i};
            rx_sync_iq <= {hdmirx_hsync_i, hdmirx_vsync_i, hdmirx_de_i};
            rx_sync_q  <= rx_sync_iq;
            {capt_hsync_o, capt_vsync_o, capt_de_o} <= capture_sel_i ? rx_sync_q
                                                                     : isl_sync_q;
        end
    end

endmodule
`default_nettype wire

//--- verilog/osd_output_stage.sv
`timescale 1ns/1ps
`default_nettype none
/* OSD colour overlay and the launch registers for the HDMI transmitter pins.
   Two cycles from rgb_i and the OSD inputs to the outputs. */
module osd_output_stage (
    input  wire                        pclk_out,
    input  wire                        po_reset_n,
    input  wire [ossc_pkg::RGB_W-1:0]  rgb_i,
    input  wire                        hsync_i,
    input  wire                        vsync_i,
    input  wire                        de_i,
    input  wire                        osd_enable_i,
    input  wire [1:0]                  osd_color_i,
    output logic [ossc_pkg::PIX_W-1:0] hdmitx_r_o,
    output logic [ossc_pkg::PIX_W-1:0] hdmitx_g_o,
    output logic [ossc_pkg::PIX_W-1:0] hdmitx_b_o,
    output logic                       hdmitx_hsync_o,
    output logic                       hdmitx_vsync_o,
    output logic                       hdmitx_de_o
);

    logic [ossc_pkg::RGB_W-1:0] osd_rgb;
    logic [ossc_pkg::RGB_W-1:0] rgb_out;
    logic hsync_out;
    logic vsync_out;
    logic de_out;

    always_comb begin
        case (osd_color_i)
            2'd0:    osd_rgb = ossc_pkg::OSD_BLACK;
            2'd1:    osd_rgb = ossc_pkg::OSD_BLUE;
            2'd2:    osd_rgb = ossc_pkg::OSD_YELLOW;
            default: osd_rgb = ossc_pkg::OSD_WHITE;
        endcase
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            rgb_out   <= '0;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
            de_out    <= 1'b0;
            {hdmitx_r_o, hdmitx_g_o, hdmitx_b_o} <= '0;
            hdmitx_hsync_o <= 1'b0;
            hdmitx_vsync_o <= 1'b0;
            hdmitx_de_o    <= 1'b0;
        end else begin
            // Overlay stage with sync passed alongside untouched
            rgb_out   <= osd_enable_i ? osd_rgb : rgb_i;
            hsync_out <= hsync_i;
            vsync_out <= vsync_i;
            de_out    <= de_i;
            // Launch stage for the transmitter
            {hdmitx_r_o, hdmitx_g_o, hdmitx_b_o} <= rgb_out;
            hdmitx_hsync_o <= hsync_out;
            hdmitx_vsync_o <= vsync_out;
            hdmitx_de_o    <= de_out;
        end
    end

endmodule
`default_nettype wire

//--- verilog/pwm_2ch.sv
`timescale 1ns/1ps
`default_nettype none
/* Two PWM channels sharing one free-running counter.
   A channel is high while the counter's top bits are below its duty. */
module pwm_2ch (
    input  wire                         pclk_out,
    input  wire                         po_reset_n,
    input  wire [ossc_pkg::DUTY_W-1:0]  ch1_duty_i,
    input  wire [ossc_pkg::DUTY_W-1:0]  ch2_duty_i,
    output logic                        ch1_pwm_o,
    output logic                        ch2_pwm_o
);

    logic [ossc_pkg::PWM_CNT_W-1:0] pwm_cnt;
    logic [ossc_pkg::DUTY_W-1:0]    pwm_phase;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    // 16 phases per period
    assign pwm_phase = pwm_cnt[ossc_pkg::PWM_CNT_W-1 -: ossc_pkg::DUTY_W];

    assign ch1_pwm_o = (pwm_phase < ch1_duty_i);
    assign ch2_pwm_o = (pwm_phase < ch2_duty_i);

endmodule
`default_nettype wire

//--- verilog/board_indicators.sv
`timescale 1ns/1ps
`default_nettype none
/* Button and resync-strobe synchronizers, resync LED hold counter,
   LED colour mapping and the active-low fan PWM output. */
module board_indicators (
    input  wire                         pclk_out,
    input  wire                         po_reset_n,
    input  wire                         poweron_i,
    input  wire                         framelock_i,
    input  wire [ossc_pkg::DUTY_W-1:0]  fan_duty_i,
    input  wire [ossc_pkg::DUTY_W-1:0]  led_duty_i,
    input  wire [ossc_pkg::BTN_W-1:0]   btn_i,
    input  wire                         resync_strobe_i,
    output logic [2:0]                  led_o,
    output logic                        fan_pwm_o,
    output logic [ossc_pkg::BTN_W-1:0]  btn_sync_o
);

    logic [ossc_pkg::BTN_W-1:0]           btn_sync1;
    logic                                 strobe_sync1;
    logic                                 strobe_sync2;
    logic                                 strobe_prev;
    logic [ossc_pkg::RESYNC_LED_BITS-1:0] resync_led_cnt;
    logic                                 fan_pwm;
    logic                                 led_pwm;

    pwm_2ch u_pwm_2ch (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .ch1_duty_i (fan_duty_i),
        .ch2_duty_i (led_duty_i),
        .ch1_pwm_o  (fan_pwm),
        .ch2_pwm_o  (led_pwm)
    );

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            // Buttons are active low and reset to released
            btn_sync1    <= '1;
            btn_sync_o   <= '1;
            strobe_sync1 <= 1'b0;
            strobe_sync2 <= 1'b0;
            strobe_prev  <= 1'b0;
        end else begin
            btn_sync1    <= btn_i;
            btn_sync_o   <= btn_sync1;
            strobe_sync1 <= resync_strobe_i;
            strobe_sync2 <= strobe_sync1;
            strobe_prev  <= strobe_sync2;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            resync_led_cnt <= '0;
        end else if (!poweron_i) begin
            resync_led_cnt <= '0;
        end else if (strobe_sync2 && !strobe_prev) begin
            resync_led_cnt <= '1;
        end else if (resync_led_cnt != '0) begin
            resync_led_cnt <= resync_led_cnt - 1'b1;
        end
    end

    // Bits are B, G, R from high to low
    assign led_o = poweron_i ? ({3{led_pwm}} & {framelock_i, ~&btn_sync_o,
                                                 resync_led_cnt != '0})
                             : 3'b000;

    assign fan_pwm_o = ~(poweron_i & fan_pwm);

endmodule
`default_nettype wire

//--- verilog/dram_refresh_sched.sv
`timescale 1ns/1ps
`default_nettype none
/* DRAM refresh scheduler. Raises a four-phase refresh request to the memory
   controller every REFRESH_INTERVAL cycles while enabled. */
module dram_refresh_sched (
    input  wire  pclk_out,
    input  wire  po_reset_n,
    input  wire  enable_i,
    input  wire  refresh_ack_i,
    output logic refresh_req_o
);

    localparam logic [1:0] ST_COUNT    = 2'd0;
    localparam logic [1:0] ST_REQ      = 2'd1;
    localparam logic [1:0] ST_ACK_LOW  = 2'd2;
    localparam logic [1:0] ST_DISABLED = 2'd3;

    logic [1:0]                         state;
    logic [ossc_pkg::REFRESH_CNT_W-1:0] refresh_cnt;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            state       <= ST_COUNT;
            refresh_cnt <= '0;
        end else begin
            case (state)
                ST_COUNT: begin
                    if (!enable_i) begin
                        state       <= ST_DISABLED;
                        refresh_cnt <= '0;
                    end else if (refresh_cnt == ossc_pkg::REFRESH_INTERVAL - 1'b1) begin
                        state       <= ST_REQ;
                        refresh_cnt <= ossc_pkg::REFRESH_INTERVAL;
                    end else begin
                        refresh_cnt <= refresh_cnt + 1'b1;
                    end
                end
                // Counter holds while the controller stalls
                ST_REQ: begin
                    if (refresh_ack_i) begin
                        state <= ST_ACK_LOW;
                    end
                end
                ST_ACK_LOW: begin
                    if (!refresh_ack_i) begin
                        state       <= enable_i ? ST_COUNT : ST_DISABLED;
                        refresh_cnt <= '0;
                    end
                end
                default: begin
                    refresh_cnt <= '0;
                    if (enable_i) begin
                        state <= ST_COUNT;
                    end
                end
            endcase
        end
    end

    assign refresh_req_o = (state == ST_REQ);

endmodule
`default_nettype wire

//--- verilog/ossc_video_top.sv
`timescale 1ns/1ps
`default_nettype none
/* Video path and board-service top level of the scan converter.
   sys_ctrl_i from the CPU selects the source, audio routing and indicators. */
module ossc_video_top (
    input  wire                         pclk_out,
    input  wire                         po_reset_n,
    input  wire [31:0]                  sys_ctrl_i,
    input  wire [ossc_pkg::PIX_W-1:0]   isl_r_i,
    input  wire [ossc_pkg::PIX_W-1:0]   isl_g_i,
    input  wire [ossc_pkg::PIX_W-1:0]   isl_b_i,
    input  wire                         isl_hsync_i,
    input  wire                         isl_vsync_i,
    input  wire                         isl_de_i,
    input  wire [ossc_pkg::PIX_W-1:0]   hdmirx_r_i,
    input  wire [ossc_pkg::PIX_W-1:0]   hdmirx_g_i,
    input  wire [ossc_pkg::PIX_W-1:0]   hdmirx_b_i,
    input  wire                         hdmirx_hsync_i,
    input  wire                         hdmirx_vsync_i,
    input  wire                         hdmirx_de_i,
    input  wire                         osd_enable_i,
    input  wire [1:0]                   osd_color_i,
    input  wire [ossc_pkg::BTN_W-1:0]   btn_i,
    input  wire                         resync_strobe_i,
    input  wire                         pcm_i2s_bck_i,
    input  wire                         pcm_i2s_ws_i,
    input  wire                         pcm_i2s_data_i,
    input  wire                         hdmirx_i2s_bck_i,
    input  wire                         hdmirx_i2s_ws_i,
    input  wire                         hdmirx_ap_i,
    input  wire                         spdif_ext_i,
    input  wire                         refresh_ack_i,
    output logic [ossc_pkg::PIX_W-1:0]  hdmitx_r_o,
    output logic [ossc_pkg::PIX_W-1:0]  hdmitx_g_o,
    output logic [ossc_pkg::PIX_W-1:0]  hdmitx_b_o,
    output logic                        hdmitx_hsync_o,
    output logic                        hdmitx_vsync_o,
    output logic                        hdmitx_de_o,
    output logic                        hdmitx_i2s_bck_o,
    output logic                        hdmitx_i2s_ws_o,
    output logic                        hdmitx_i2s_data_o,
    output logic                        hdmitx_spdif_o,
    output logic                        audmux_o,
    output logic                        hdmitx_5v_en_o,
    output logic [2:0]                  led_o,
    output logic                        fan_pwm_o,
    output logic [ossc_pkg::BTN_W-1:0]  btn_sync_o,
    output logic                        refresh_req_o
);

    // sys_ctrl fields
    wire sys_poweron  = sys_ctrl_i[ossc_pkg::SYS_POWERON_BIT];
    wire capture_sel  = sys_ctrl_i[ossc_pkg::CAPTURE_SEL_BIT];
    wire audmux_sel   = sys_ctrl_i[ossc_pkg::AUDMUX_SEL_BIT];
    wire framelock    = sys_ctrl_i[ossc_pkg::FRAMELOCK_BIT];
    wire hdmirx_spdif = sys_ctrl_i[ossc_pkg::HDMIRX_SPDIF_BIT];
    wire refresh_en   = sys_ctrl_i[ossc_pkg::REFRESH_EN_BIT];
    wire [ossc_pkg::DUTY_W-1:0] fan_duty = sys_ctrl_i[ossc_pkg::FAN_DUTY_LSB +: ossc_pkg::DUTY_W];
    wire [ossc_pkg::DUTY_W-1:0] led_duty = sys_ctrl_i[ossc_pkg::LED_DUTY_LSB +: ossc_pkg::DUTY_W];

    logic [ossc_pkg::RGB_W-1:0] capt_rgb;
    logic capt_hsync;
    logic capt_vsync;
    logic capt_de;

    capture_mux u_capture_mux (
        .pclk_out       (pclk_out),
        .po_reset_n     (po_reset_n),
        .capture_sel_i  (capture_sel),
        .isl_r_i        (isl_r_i),
        .isl_g_i        (isl_g_i),
        .isl_b_i        (isl_b_i),
        .isl_hsync_i    (isl_hsync_i),
        .isl_vsync_i    (isl_vsync_i),
        .isl_de_i       (isl_de_i),
        .hdmirx_r_i     (hdmirx_r_i),
        .hdmirx_g_i     (hdmirx_g_i),
        .hdmirx_b_i     (hdmirx_b_i),
        .hdmirx_hsync_i (hdmirx_hsync_i),
        .hdmirx_vsync_i (hdmirx_vsync_i),
        .hdmirx_de_i    (hdmirx_de_i),
        .capt_rgb_o     (capt_rgb),
        .capt_hsync_o   (capt_hsync),
        .capt_vsync_o   (capt_vsync),
        .capt_de_o      (capt_de)
    );

    osd_output_stage u_osd_output_stage (
        .pclk_out       (pclk_out),
        .po_reset_n     (po_reset_n),
        .rgb_i          (capt_rgb),
        .hsync_i        (capt_hsync),
        .vsync_i        (capt_vsync),
        .de_i           (capt_de),
        .osd_enable_i   (osd_enable_i),
        .osd_color_i    (osd_color_i),
        .hdmitx_r_o     (hdmitx_r_o),
        .hdmitx_g_o     (hdmitx_g_o),
        .hdmitx_b_o     (hdmitx_b_o),
        .hdmitx_hsync_o (hdmitx_hsync_o),
        .hdmitx_vsync_o (hdmitx_vsync_o),
        .hdmitx_de_o    (hdmitx_de_o)
    );

    board_indicators u_board_indicators (
        .pclk_out        (pclk_out),
        .po_reset_n      (po_reset_n),
        .poweron_i       (sys_poweron),
        .framelock_i     (framelock),
        .fan_duty_i      (fan_duty),
        .led_duty_i      (led_duty),
        .btn_i           (btn_i),
        .resync_strobe_i (resync_strobe_i),
        .led_o           (led_o),
        .fan_pwm_o       (fan_pwm_o),
        .btn_sync_o      (btn_sync_o)
    );

    dram_refresh_sched u_dram_refresh_sched (
        .pclk_out      (pclk_out),
        .po_reset_n    (po_reset_n),
        .enable_i      (refresh_en),
        .refresh_ack_i (refresh_ack_i),
        .refresh_req_o (refresh_req_o)
    );

    // Audio follows the video source
    assign hdmitx_i2s_bck_o  = capture_sel ? hdmirx_i2s_bck_i : pcm_i2s_bck_i;
    assign hdmitx_i2s_ws_o   = capture_sel ? hdmirx_i2s_ws_i : pcm_i2s_ws_i;
    assign hdmitx_i2s_data_o = capture_sel ? hdmirx_ap_i : pcm_i2s_data_i;
    assign hdmitx_spdif_o    = hdmirx_spdif ? hdmirx_ap_i : spdif_ext_i;

    assign audmux_o       = ~audmux_sel;
    assign hdmitx_5v_en_o = sys_poweron;

endmodule
`default_nettype wire

//--- include/ossc_tb_checks.svh
/* Compare tasks and LFSR helpers for the top-level testbench.
   Included inside the testbench module; each task adds to the error count it is given. */
`ifndef OSSC_TB_CHECKS_SVH
`define OSSC_TB_CHECKS_SVH

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// One step per bit taken with bits returned right aligned
function automatic logic [31:0] lfsr_bits(inout logic [31:0] state, input int nbits);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
        state = lfsr_step(state);
        bits  = {bits[30:0], state[0]};
    end
    return bits;
endfunction

task automatic check_pixel(input string what, input logic [ossc_pkg::RGB_W-1:0] got,
                           input logic [ossc_pkg::RGB_W-1:0] exp, inout int errs);
    if (got !== exp) begin
        errs++;
        $display("ERROR %0t: %s pixel %h, expected %h", $time, what, got, exp);
    end
endtask

// Triple is {hsync, vsync, de}
task automatic check_sync(input string what, input logic [2:0] got,
                          input logic [2:0] exp, inout int errs);
    if (got !== exp) begin
        errs++;
        $display("ERROR %0t: %s sync %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_led(input string what, input logic [2:0] got,
                         input logic [2:0] exp, inout int errs);
    if (got !== exp) begin
        errs++;
        $display("ERROR %0t: %s led %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_buttons(input string what, input logic [ossc_pkg::BTN_W-1:0] got,
                             input logic [ossc_pkg::BTN_W-1:0] exp, inout int errs);
    if (got !== exp) begin
        errs++;
        $display("ERROR %0t: %s buttons %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_flag(input string what, input logic got,
                          input logic exp, inout int errs);
    if (got !== exp) begin
        errs++;
        $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

`endif

//--- sim/tb_ossc_video_top.sv
`timescale 1ns/1ps
`default_nettype none
/* Top-level testbench of the scan-converter video path and board services.
   Compile with list.f and run tb_ossc_video_top as the top module. */
module tb_ossc_video_top;

    localparam int CLK_PERIOD     = 40;
    localparam logic [31:0] SEED  = 32'head4;
    localparam int DIG_LAT        = 4;
    localparam int RX_LAT         = 5;
    localparam int OSD_LAT        = 2;
    localparam int HIST_DEPTH     = RX_LAT;
    localparam int PIX_CYCLES     = 300;
    localparam int OSD_CYCLES     = 300;
    localparam int REFRESHES      = 5;
    localparam int REFRESH_MIN    = 842;
    localparam int REFRESH_MAX    = 844;
    localparam int REFRESH_SLOT   = REFRESH_MAX + 16 + 4;
    localparam int IDLE_CYCLES    = 2000;
    localparam int LED_WINDOW     = 80;
    localparam int STROBE_WINDOW  = 70;
    localparam int PWR_OFF_CYCLES = 1100;
    localparam int AUDIO_CYCLES   = 64;
    localparam int TEST_CYCLES    = 2 * PIX_CYCLES + OSD_CYCLES + REFRESHES * REFRESH_SLOT
                                  + IDLE_CYCLES + LED_WINDOW + STROBE_WINDOW
                                  + PWR_OFF_CYCLES + AUDIO_CYCLES;
    localparam int TIMEOUT_NS     = (TEST_CYCLES + 4000) * CLK_PERIOD;

    // One input cycle of the video path
    typedef struct packed {
        logic                       sel;
        logic [ossc_pkg::RGB_W-1:0] isl_rgb;
        logic [2:0]                 isl_sync;
        logic [ossc_pkg::RGB_W-1:0] rx_rgb;
        logic [2:0]                 rx_sync;
        logic                       osd_en;
        logic [1:0]                 osd_col;
    } video_in_t;

    logic                        pclk_out;
    logic                        po_reset_n;
    logic [31:0]                 sys_ctrl_i;
    logic [ossc_pkg::PIX_W-1:0]  isl_r_i, isl_g_i, isl_b_i;
    logic                        isl_hsync_i, isl_vsync_i, isl_de_i;
    logic [ossc_pkg::PIX_W-1:0]  hdmirx_r_i, hdmirx_g_i, hdmirx_b_i;
    logic                        hdmirx_hsync_i, hdmirx_vsync_i, hdmirx_de_i;
    logic                        osd_enable_i;
    logic [1:0]                  osd_color_i;
    logic [ossc_pkg::BTN_W-1:0]  btn_i;
    logic                        resync_strobe_i;
    logic                        pcm_i2s_bck_i, pcm_i2s_ws_i, pcm_i2s_data_i;
    logic                        hdmirx_i2s_bck_i, hdmirx_i2s_ws_i, hdmirx_ap_i;
    logic                        spdif_ext_i;
    logic                        refresh_ack_i;
    logic [ossc_pkg::PIX_W-1:0]  hdmitx_r_o, hdmitx_g_o, hdmitx_b_o;
    logic                        hdmitx_hsync_o, hdmitx_vsync_o, hdmitx_de_o;
    logic                        hdmitx_i2s_bck_o, hdmitx_i2s_ws_o, hdmitx_i2s_data_o;
    logic                        hdmitx_spdif_o, audmux_o, hdmitx_5v_en_o;
    logic [2:0]                  led_o;
    logic                        fan_pwm_o;
    logic [ossc_pkg::BTN_W-1:0]  btn_sync_o;
    logic                        refresh_req_o;

    logic [31:0] pix_lfsr;
    logic [31:0] ack_lfsr;
    video_in_t   hist[$];
    int          pix_errs;
    int          hs_errs;
    int          misc_errs;
    int          pix_checks;
    int          refresh_count;

    `include "ossc_tb_checks.svh"

    ossc_video_top u_ossc_video_top (.*);

    initial begin
        pclk_out = 1'b0;
        forever #(CLK_PERIOD / 2) pclk_out = ~pclk_out;
    end

    // Expected {rgb, hsync, vsync, de} on the transmitter pins
    function automatic logic [ossc_pkg::RGB_W+2:0] expected_video(input video_in_t osd_in,
            input video_in_t sel_in, input video_in_t isl_in, input video_in_t rx_in);
        logic [ossc_pkg::RGB_W-1:0] rgb;
        logic [2:0]                 sync;
        rgb  = sel_in.sel ? rx_in.rx_rgb : isl_in.isl_rgb;
        sync = sel_in.sel ? rx_in.rx_sync : isl_in.isl_sync;
        if (osd_in.osd_en) begin
            case (osd_in.osd_col)
                2'd0:    rgb = 24'h000000;
                2'd1:    rgb = 24'h0000ff;
                2'd2:    rgb = 24'hffff00;
                default: rgb = 24'hffffff;
            endcase
        end
        return {rgb, sync};
    endfunction

    task automatic drive_video(input logic osd_rand);
        logic [31:0] r;
        r = lfsr_bits(pix_lfsr, 27);
        {isl_r_i, isl_g_i, isl_b_i} = r[26:3];
        {isl_hsync_i, isl_vsync_i, isl_de_i} = r[2:0];
        r = lfsr_bits(pix_lfsr, 27);
        {hdmirx_r_i, hdmirx_g_i, hdmirx_b_i} = r[26:3];
        {hdmirx_hsync_i, hdmirx_vsync_i, hdmirx_de_i} = r[2:0];
        if (osd_rand) begin
            r = lfsr_bits(pix_lfsr, 3);
            {osd_enable_i, osd_color_i} = r[2:0];
        end
    endtask

    task automatic run_video(input logic sel, input logic osd_rand, input int cycles);
        repeat (cycles) begin
            @(negedge pclk_out);
            sys_ctrl_i[ossc_pkg::CAPTURE_SEL_BIT] = sel;
            drive_video(osd_rand);
        end
    endtask

    initial begin : compare_video
        video_in_t                  now_in;
        logic [ossc_pkg::RGB_W+2:0] exp_v;
        forever begin
            @(posedge pclk_out);
            if (!po_reset_n) begin
                hist.delete();
            end else begin
                // hist[0] is the cycle before this edge
                if (hist.size() == HIST_DEPTH) begin
                    exp_v = expected_video(hist[OSD_LAT-1], hist[DIG_LAT-2],
                                           hist[DIG_LAT-1], hist[RX_LAT-1]);
                    check_pixel("hdmitx rgb", {hdmitx_r_o, hdmitx_g_o, hdmitx_b_o},
                                exp_v[ossc_pkg::RGB_W+2:3], pix_errs);
                    check_sync("hdmitx sync", {hdmitx_hsync_o, hdmitx_vsync_o,
                               hdmitx_de_o}, exp_v[2:0], pix_errs);
                    pix_checks++;
                end
                now_in.sel      = sys_ctrl_i[ossc_pkg::CAPTURE_SEL_BIT];
                now_in.isl_rgb  = {isl_r_i, isl_g_i, isl_b_i};
                now_in.isl_sync = {isl_hsync_i, isl_vsync_i, isl_de_i};
                now_in.rx_rgb   = {hdmirx_r_i, hdmirx_g_i, hdmirx_b_i};
                now_in.rx_sync  = {hdmirx_hsync_i, hdmirx_vsync_i, hdmirx_de_i};
                now_in.osd_en   = osd_enable_i;
                now_in.osd_col  = osd_color_i;
                hist.push_front(now_in);
                if (hist.size() > HIST_DEPTH) begin
                    void'(hist.pop_back());
                end
            end
        end
    end

    // Memory controller side of the refresh handshake
    initial begin : ack_responder
        logic [31:0] r;
        refresh_ack_i = 1'b0;
        forever begin
            @(negedge pclk_out);
            if (refresh_req_o) begin
                r = lfsr_bits(ack_lfsr, 4);
                repeat (r[3:0]) @(negedge pclk_out);
                refresh_ack_i = 1'b1;
                while (refresh_req_o) @(negedge pclk_out);
                refresh_ack_i = 1'b0;
            end
        end
    end

    initial begin : refresh_monitor
        logic req_prev;
        logic ack_prev;
        logic armed;
        int   since_low;
        req_prev  = 1'b0;
        ack_prev  = 1'b0;
        armed     = 1'b0;
        since_low = 0;
        forever begin
            @(posedge pclk_out);
            if (!po_reset_n) begin
                req_prev = 1'b0;
                ack_prev = 1'b0;
                armed    = 1'b0;
            end else begin
                since_low++;
                if (req_prev && !refresh_req_o && !ack_prev) begin
                    hs_errs++;
                    $display("ERROR %0t: refresh req fell before ack was high", $time);
                end
                if (!req_prev && refresh_req_o) begin
                    if (ack_prev) begin
                        hs_errs++;
                        $display("ERROR %0t: refresh req rose while ack was high", $time);
                    end
                    if (armed && (since_low < REFRESH_MIN || since_low > REFRESH_MAX)) begin
                        hs_errs++;
                        $display("ERROR %0t: refresh req rose %0d cycles after ack low",
                                 $time, since_low);
                    end
                    refresh_count++;
                    armed = 1'b0;
                end
                if (ack_prev && !refresh_ack_i) begin
                    since_low = 0;
                    armed     = 1'b1;
                end
                req_prev = refresh_req_o;
                ack_prev = refresh_ack_i;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        logic        seen;
        int          start_count;
        pix_lfsr   = SEED;
        ack_lfsr   = SEED;
        pix_errs   = 0;
        hs_errs    = 0;
        misc_errs  = 0;
        pix_checks = 0;
        refresh_count = 0;
        po_reset_n = 1'b0;
        sys_ctrl_i = 32'h0000_0001;
        {isl_r_i, isl_g_i, isl_b_i, isl_hsync_i, isl_vsync_i, isl_de_i} = '0;
        {hdmirx_r_i, hdmirx_g_i, hdmirx_b_i, hdmirx_hsync_i, hdmirx_vsync_i} = '0;
        hdmirx_de_i  = 1'b0;
        osd_enable_i = 1'b0;
        osd_color_i  = 2'd0;
        btn_i        = '1;
        resync_strobe_i = 1'b0;
        {pcm_i2s_bck_i, pcm_i2s_ws_i, pcm_i2s_data_i} = '0;
        {hdmirx_i2s_bck_i, hdmirx_i2s_ws_i, hdmirx_ap_i, spdif_ext_i} = '0;
        repeat (2) @(negedge pclk_out);
        po_reset_n = 1'b1;

        // Digitizer, receiver, then OSD over both sources
        run_video(1'b0, 1'b0, PIX_CYCLES);
        run_video(1'b1, 1'b0, PIX_CYCLES);
        run_video(1'b0, 1'b1, OSD_CYCLES / 2);
        run_video(1'b1, 1'b1, OSD_CYCLES / 2);
        @(negedge pclk_out);
        osd_enable_i = 1'b0;

        start_count = refresh_count;
        sys_ctrl_i[ossc_pkg::REFRESH_EN_BIT] = 1'b1;
        while (refresh_count < start_count + REFRESHES) @(negedge pclk_out);
        sys_ctrl_i[ossc_pkg::REFRESH_EN_BIT] = 1'b0;
        while (refresh_req_o || refresh_ack_i) @(negedge pclk_out);
        repeat (IDLE_CYCLES) begin
            @(negedge pclk_out);
            check_flag("refresh req while disabled", refresh_req_o, 1'b0, misc_errs);
        end

        sys_ctrl_i[ossc_pkg::FRAMELOCK_BIT] = 1'b1;
        sys_ctrl_i[ossc_pkg::LED_DUTY_LSB +: ossc_pkg::DUTY_W] = 4'hf;
        btn_i = 6'b111110;
        seen  = 1'b0;
        repeat (LED_WINDOW) begin
            @(negedge pclk_out);
            if (led_o[2:1] == 2'b11) seen = 1'b1;
        end
        check_flag("framelock and button leds", seen, 1'b1, misc_errs);
        check_buttons("synchronized held", btn_sync_o, 6'b111110, misc_errs);
        btn_i = '1;
        resync_strobe_i = 1'b1;
        seen = 1'b0;
        repeat (STROBE_WINDOW) begin
            @(negedge pclk_out);
            if (led_o[0]) seen = 1'b1;
        end
        check_flag("resync red led", seen, 1'b1, misc_errs);
        check_buttons("synchronized released", btn_sync_o, '1, misc_errs);
        resync_strobe_i = 1'b0;

        sys_ctrl_i[ossc_pkg::SYS_POWERON_BIT] = 1'b0;
        sys_ctrl_i[ossc_pkg::FAN_DUTY_LSB +: ossc_pkg::DUTY_W] = 4'hf;
        repeat (PWR_OFF_CYCLES) begin
            @(negedge pclk_out);
            check_led("led while off", led_o, 3'b000, misc_errs);
            check_flag("fan while off", fan_pwm_o, 1'b1, misc_errs);
        end

        repeat (AUDIO_CYCLES) begin
            @(negedge pclk_out);
            r = lfsr_bits(pix_lfsr, 11);
            sys_ctrl_i[ossc_pkg::CAPTURE_SEL_BIT]  = r[10];
            sys_ctrl_i[ossc_pkg::HDMIRX_SPDIF_BIT] = r[9];
            sys_ctrl_i[ossc_pkg::AUDMUX_SEL_BIT]   = r[8];
            sys_ctrl_i[ossc_pkg::SYS_POWERON_BIT]  = r[7];
            {pcm_i2s_bck_i, pcm_i2s_ws_i, pcm_i2s_data_i} = r[6:4];
            {hdmirx_i2s_bck_i, hdmirx_i2s_ws_i, hdmirx_ap_i, spdif_ext_i} = r[3:0];
            #1;
            check_flag("i2s bck", hdmitx_i2s_bck_o,
                       r[10] ? hdmirx_i2s_bck_i : pcm_i2s_bck_i, misc_errs);
            check_flag("i2s ws", hdmitx_i2s_ws_o,
                       r[10] ? hdmirx_i2s_ws_i : pcm_i2s_ws_i, misc_errs);
            check_flag("i2s data", hdmitx_i2s_data_o,
                       r[10] ? hdmirx_ap_i : pcm_i2s_data_i, misc_errs);
            check_flag("spdif", hdmitx_spdif_o, r[9] ? hdmirx_ap_i : spdif_ext_i,
                       misc_errs);
            check_flag("audmux", audmux_o, ~r[8], misc_errs);
            check_flag("5v enable", hdmitx_5v_en_o, r[7], misc_errs);
        end
        repeat (8) @(negedge pclk_out);

        if (pix_checks < 2 * PIX_CYCLES + OSD_CYCLES) begin
            misc_errs++;
            $display("Too few video compares were made: %0d", pix_checks);
        end
        $display("Errors: video %0d, refresh %0d, board and audio %0d",
                 pix_errs, hs_errs, misc_errs);
        if (pix_errs + hs_errs + misc_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
`default_nettype wire

//--- list.f
+incdir+include
verilog/ossc_pkg.sv
verilog/capture_mux.sv
verilog/osd_output_stage.sv
verilog/pwm_2ch.sv
verilog/board_indicators.sv
verilog/dram_refresh_sched.sv
verilog/ossc_video_top.sv
sim/tb_ossc_video_top.sv
